//--- hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ------------------------------
// core sizing
// ------------------------------

// datapath width.
`define CORE_XLEN 32

// architectural registers, x0 included.
`define CORE_NREG 32

// bits of a register address.
`define CORE_RADDR 5

// scoreboard tag width.
// a wider tag allows more writes in flight to one register.
`define CORE_TAG_BITS 3

`endif

//--- hw/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL
    } alu_op_e;

    // one decoded instruction on its way down the pipe.
    typedef struct packed {
        logic                      valid;
        alu_op_e                   op;
        logic [`CORE_RADDR-1:0]    rs1;
        logic                      rs1_en;
        logic [`CORE_RADDR-1:0]    rs2;
        logic                      rs2_en;
        logic [`CORE_RADDR-1:0]    rd;
        logic                      rd_en;
        logic [`CORE_XLEN-1:0]     imm;
        logic                      use_imm;
        logic [`CORE_TAG_BITS-1:0] tag;
        logic [`CORE_XLEN-1:0]     operand_a;
        logic [`CORE_XLEN-1:0]     operand_b;
    } uop_t;

    // result returning to the register file.
    typedef struct packed {
        logic                      valid;
        logic [`CORE_RADDR-1:0]    rd;
        logic [`CORE_TAG_BITS-1:0] tag;
        logic [`CORE_XLEN-1:0]     data;
    } wb_t;

endpackage

//--- hw/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     hold_i,
    input  payload_t d_i,
    input  logic     d_valid_i,
    output payload_t q_o,
    output logic     q_valid_o
);

    // valid follows the load enable and is the only reset bit.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            q_valid_o <= 1'b0;
        end else if (!hold_i) begin
            q_valid_o <= d_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [31:0]       instr_i,
    input  logic              instr_req_i,
    output logic              instr_ack_o,
    input  logic              hold_i,
    output core_pkg::uop_t    uop_o,
    output logic              illegal_o
);

    import core_pkg::*;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic accept;
    logic legal;
    uop_t dec;
    uop_t dec_q;
    logic dec_valid_q;

    // ------------------------------
    // four-phase port
    // ------------------------------

    // take a word only on a fresh req and when the next stage can move.
    assign accept = instr_req_i && !instr_ack_o && !hold_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            instr_ack_o <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            if (accept) begin
                instr_ack_o <= 1'b1;
            end else if (!instr_req_i) begin
                instr_ack_o <= 1'b0;
            end
            illegal_o <= accept && !legal;
        end
    end

    // ------------------------------
    // decoder
    // ------------------------------

    always_comb begin
        dec         = '0;
        legal       = 1'b0;
        dec.op      = OP_NOP;
        dec.rs1     = instr_i[19:15];
        dec.rs2     = instr_i[24:20];
        dec.rd      = instr_i[11:7];
        dec.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        case (instr_i[6:0])
            OPC_REG: begin
                legal      = 1'b1;
                dec.rs1_en = 1'b1;
                dec.rs2_en = 1'b1;
                case ({instr_i[31:25], instr_i[14:12]})
                    10'b0000000_000: dec.op = OP_ADD;
                    10'b0100000_000: dec.op = OP_SUB;
                    10'b0000000_001: dec.op = OP_SLL;
                    10'b0000000_010: dec.op = OP_SLT;
                    10'b0000000_100: dec.op = OP_XOR;
                    10'b0000000_101: dec.op = OP_SRL;
                    10'b0000000_110: dec.op = OP_OR;
                    10'b0000000_111: dec.op = OP_AND;
                    default:         legal  = 1'b0;
                endcase
            end
            OPC_IMM: begin
                // only ADDI in the immediate group.
                if (instr_i[14:12] == 3'b000) begin
                    legal       = 1'b1;
                    dec.op      = OP_ADD;
                    dec.rs1_en  = 1'b1;
                    dec.use_imm = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
        // writes to x0 are dropped here.
        dec.rd_en = legal && (dec.rd != '0);
        dec.valid = legal;
    end

    stage_reg #(
        .payload_t (uop_t)
    ) u_dec_reg (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hold_i    (hold_i),
        .d_i       (dec),
        .d_valid_i (accept && legal),
        .q_o       (dec_q),
        .q_valid_o (dec_valid_q)
    );

    always_comb begin
        uop_o       = dec_q;
        uop_o.valid = dec_valid_q;
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

`include "core_defines.svh"

module reg_file (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic [`CORE_RADDR-1:0]    rd_addr1_i,
    input  logic [`CORE_RADDR-1:0]    rd_addr2_i,
    output logic [`CORE_XLEN-1:0]     rd_data1_o,
    output logic [`CORE_XLEN-1:0]     rd_data2_o,
    output logic                      rd_ready1_o,
    output logic                      rd_ready2_o,
    input  core_pkg::wb_t             wb_i,
    input  logic                      alloc_en_i,
    input  logic [`CORE_RADDR-1:0]    alloc_addr_i,
    input  logic [`CORE_TAG_BITS-1:0] alloc_tag_i
);

    logic [`CORE_XLEN-1:0]     regs_q [`CORE_NREG];
    logic [`CORE_TAG_BITS-1:0] tag_q [`CORE_NREG];
    logic [`CORE_NREG-1:0]     pending_q;

    // a writeback for this register in the current cycle.
    function automatic logic wb_hit(input logic [`CORE_RADDR-1:0] addr);
        return wb_i.valid && (wb_i.rd == addr);
    endfunction

    function automatic logic port_ready(input logic [`CORE_RADDR-1:0] addr);
        return (addr == '0) || !pending_q[addr] ||
               (wb_hit(addr) && (wb_i.tag == tag_q[addr]));
    endfunction

    function automatic logic [`CORE_XLEN-1:0] port_data(input logic [`CORE_RADDR-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        return wb_hit(addr) ? wb_i.data : regs_q[addr];
    endfunction

    always_comb begin
        rd_ready1_o = port_ready(rd_addr1_i);
        rd_ready2_o = port_ready(rd_addr2_i);
        rd_data1_o  = port_data(rd_addr1_i);
        rd_data2_o  = port_data(rd_addr2_i);
    end

    always_ff @(posedge clk_i) begin
        if (wb_i.valid && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
        if (alloc_en_i) begin
            tag_q[alloc_addr_i] <= alloc_tag_i;
        end
    end

    // a new allocation wins over a release in the same cycle.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
        end else begin
            if (wb_i.valid && (wb_i.tag == tag_q[wb_i.rd])) begin
                pending_q[wb_i.rd] <= 1'b0;
            end
            if (alloc_en_i && (alloc_addr_i != '0)) begin
                pending_q[alloc_addr_i] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/reg_read_stage.sv
`timescale 1ns/1ns

`include "core_defines.svh"

module reg_read_stage (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  core_pkg::uop_t            uop_i,
    input  logic                      uop_valid_i,
    input  logic                      hold_i,
    output logic                      stall_o,
    output core_pkg::uop_t            uop_o,
    output logic [`CORE_RADDR-1:0]    rd_addr1_o,
    output logic [`CORE_RADDR-1:0]    rd_addr2_o,
    input  logic [`CORE_XLEN-1:0]     rd_data1_i,
    input  logic [`CORE_XLEN-1:0]     rd_data2_i,
    input  logic                      rd_ready1_i,
    input  logic                      rd_ready2_i,
    output logic                      alloc_en_o,
    output logic [`CORE_RADDR-1:0]    alloc_addr_o,
    output logic [`CORE_TAG_BITS-1:0] alloc_tag_o
);

    import core_pkg::*;

    logic                      src_wait;
    logic [`CORE_TAG_BITS-1:0] tag_q;
    logic [`CORE_TAG_BITS-1:0] tag_n;
    uop_t                      uop_n;

    assign rd_addr1_o = uop_i.rs1;
    assign rd_addr2_o = uop_i.rs2;

    // wait while a source in use still has a write outstanding.
    assign src_wait = uop_valid_i &&
                      ((uop_i.rs1_en && !rd_ready1_i) || (uop_i.rs2_en && !rd_ready2_i));
    assign stall_o  = src_wait || hold_i;

    assign tag_n        = tag_q + 1'b1;
    assign alloc_en_o   = uop_valid_i && !stall_o && uop_i.rd_en;
    assign alloc_addr_o = uop_i.rd;
    assign alloc_tag_o  = tag_n;

    always_comb begin
        uop_n           = uop_i;
        uop_n.valid     = uop_valid_i && !src_wait;
        uop_n.operand_a = rd_data1_i;
        uop_n.operand_b = uop_i.use_imm ? uop_i.imm : rd_data2_i;
        uop_n.tag       = tag_n;
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            uop_o <= uop_n;
        end
        if (!rstn_i) begin
            uop_o.valid <= 1'b0;
            tag_q       <= '0;
        end else if (alloc_en_o) begin
            tag_q <= tag_n;
        end
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ns

`include "core_defines.svh"

module execute_stage (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  core_pkg::uop_t uop_i,
    output logic           busy_o,
    output core_pkg::wb_t  wb_o
);

    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic                  is_shift;
    logic [SHAMT_W-1:0]    shamt;
    logic                  running_q;
    logic [SHAMT_W-1:0]    cnt_q;
    logic [`CORE_XLEN-1:0] sh_q;
    logic [`CORE_XLEN-1:0] sh_src;
    logic [`CORE_XLEN-1:0] sh_step;
    logic [`CORE_XLEN-1:0] result;

    // ------------------------------
    // bit-serial shifter
    // ------------------------------

    assign is_shift = uop_i.valid && ((uop_i.op == OP_SLL) || (uop_i.op == OP_SRL));
    assign shamt    = uop_i.operand_b[SHAMT_W-1:0];
    assign sh_src   = running_q ? sh_q : uop_i.operand_a;
    assign sh_step  = (uop_i.op == OP_SLL) ? (sh_src << 1) : (sh_src >> 1);

    // one bit per cycle, the uop stays at the input until the last bit.
    assign busy_o = is_shift && (running_q ? (cnt_q != '0) : (shamt != '0));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            running_q <= 1'b0;
        end else begin
            running_q <= busy_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy_o) begin
            sh_q  <= sh_step;
            cnt_q <= running_q ? cnt_q - 1'b1 : shamt - 1'b1;
        end
    end

    always_comb begin
        case (uop_i.op)
            OP_ADD:  result = uop_i.operand_a + uop_i.operand_b;
            OP_SUB:  result = uop_i.operand_a - uop_i.operand_b;
            OP_AND:  result = uop_i.operand_a & uop_i.operand_b;
            OP_OR:   result = uop_i.operand_a | uop_i.operand_b;
            OP_XOR:  result = uop_i.operand_a ^ uop_i.operand_b;
            OP_SLT:  result = {{(`CORE_XLEN-1){1'b0}},
                               $signed(uop_i.operand_a) < $signed(uop_i.operand_b)};
            OP_SLL,
            OP_SRL:  result = sh_src;
            default: result = '0;
        endcase
    end

    // ------------------------------
    // writeback register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        wb_o.rd   <= uop_i.rd;
        wb_o.tag  <= uop_i.tag;
        wb_o.data <= result;
        if (!rstn_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= uop_i.valid && uop_i.rd_en && !busy_o;
        end
    end

endmodule

//--- hw/core_pipe_top.sv
`timescale 1ns/1ns

`include "core_defines.svh"

module core_pipe_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic [31:0]            instr_i,
    input  logic                   instr_req_i,
    output logic                   instr_ack_o,
    output logic                   illegal_o,
    output logic                   wb_valid_o,
    output logic [`CORE_RADDR-1:0] wb_rd_o,
    output logic [`CORE_XLEN-1:0]  wb_data_o
);

    import core_pkg::*;

    uop_t                      dec_uop;
    uop_t                      rr_uop;
    wb_t                       wb;
    logic                      rr_stall;
    logic                      ex_busy;
    logic [`CORE_RADDR-1:0]    rf_addr1;
    logic [`CORE_RADDR-1:0]    rf_addr2;
    logic [`CORE_XLEN-1:0]     rf_data1;
    logic [`CORE_XLEN-1:0]     rf_data2;
    logic                      rf_ready1;
    logic                      rf_ready2;
    logic                      alloc_en;
    logic [`CORE_RADDR-1:0]    alloc_addr;
    logic [`CORE_TAG_BITS-1:0] alloc_tag;

    decode_stage u_decode_stage (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .instr_i     (instr_i),
        .instr_req_i (instr_req_i),
        .instr_ack_o (instr_ack_o),
        .hold_i      (rr_stall),
        .uop_o       (dec_uop),
        .illegal_o   (illegal_o)
    );

    reg_read_stage u_reg_read_stage (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .uop_i        (dec_uop),
        .uop_valid_i  (dec_uop.valid),
        .hold_i       (ex_busy),
        .stall_o      (rr_stall),
        .uop_o        (rr_uop),
        .rd_addr1_o   (rf_addr1),
        .rd_addr2_o   (rf_addr2),
        .rd_data1_i   (rf_data1),
        .rd_data2_i   (rf_data2),
        .rd_ready1_i  (rf_ready1),
        .rd_ready2_i  (rf_ready2),
        .alloc_en_o   (alloc_en),
        .alloc_addr_o (alloc_addr),
        .alloc_tag_o  (alloc_tag)
    );

    reg_file u_reg_file (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rd_addr1_i   (rf_addr1),
        .rd_addr2_i   (rf_addr2),
        .rd_data1_o   (rf_data1),
        .rd_data2_o   (rf_data2),
        .rd_ready1_o  (rf_ready1),
        .rd_ready2_o  (rf_ready2),
        .wb_i         (wb),
        .alloc_en_i   (alloc_en),
        .alloc_addr_i (alloc_addr),
        .alloc_tag_i  (alloc_tag)
    );

    execute_stage u_execute_stage (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .uop_i  (rr_uop),
        .busy_o (ex_busy),
        .wb_o   (wb)
    );

    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

//--- sim/tb_core_pipe.sv
`timescale 1ns/1ns

`include "core_defines.svh"

module tb_core_pipe;

    localparam int CLK_HALF    = 2;
    localparam int NUM_ENTRIES = 25;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + 100;

    typedef struct packed {
        logic [31:0] instr;
        logic        illegal;
    } stim_t;

    typedef struct packed {
        logic [`CORE_RADDR-1:0] rd;
        logic [`CORE_XLEN-1:0]  data;
    } exp_wb_t;

    logic                   clk_i;
    logic                   rstn_i;
    logic [31:0]            instr_i;
    logic                   instr_req_i;
    logic                   instr_ack_o;
    logic                   illegal_o;
    logic                   wb_valid_o;
    logic [`CORE_RADDR-1:0] wb_rd_o;
    logic [`CORE_XLEN-1:0]  wb_data_o;

    stim_t                 stim [NUM_ENTRIES];
    logic [`CORE_XLEN-1:0] gold_regs [`CORE_NREG];
    exp_wb_t               exp_q [$];
    exp_wb_t               head_wb;
    int                    errors;
    int                    cycles;
    int                    illegal_seen;
    int                    illegal_expected;
    logic                  ack_prev;
    logic                  req_prev;

    core_pipe_top u_core_pipe_top (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .instr_i     (instr_i),
        .instr_req_i (instr_req_i),
        .instr_ack_o (instr_ack_o),
        .illegal_o   (illegal_o),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

    initial clk_i = 1'b0;
    always #CLK_HALF clk_i = ~clk_i;

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7,
                                                input logic [2:0] funct3,
                                                input logic [4:0] rd,
                                                input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd,
                                              input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    // reference result of one instruction, from the RV32I rules.
    task automatic golden_step(input logic [31:0] word);
        logic [6:0]  opcode;
        logic [6:0]  funct7;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        writes;
        opcode = word[6:0];
        funct7 = word[31:25];
        funct3 = word[14:12];
        rd     = word[11:7];
        a      = gold_regs[word[19:15]];
        b      = gold_regs[word[24:20]];
        imm    = {{20{word[31]}}, word[31:20]};
        res    = '0;
        writes = 1'b1;
        if ((opcode == 7'b0010011) && (funct3 == 3'b000)) begin
            res = a + imm;
        end else if (opcode == 7'b0110011) begin
            case ({funct7, funct3})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_001: res = a << b[4:0];
                10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                10'b0000000_100: res = a ^ b;
                10'b0000000_101: res = a >> b[4:0];
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         writes = 1'b0;
            endcase
        end else begin
            writes = 1'b0;
        end
        if (writes && (rd != 5'd0)) begin
            gold_regs[rd] = res;
            exp_q.push_back('{rd, res});
        end
    endtask

    // one full four-phase transfer.
    task automatic apply_instr(input logic [31:0] word);
        @(posedge clk_i);
        #1;
        instr_i     = word;
        instr_req_i = 1'b1;
        while (!instr_ack_o) begin
            @(posedge clk_i);
            #1;
        end
        instr_req_i = 1'b0;
        while (instr_ack_o) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic fill_table();
        stim[0]  = '{addi_word(5'd1, 5'd0, 12'd5), 1'b0};
        stim[1]  = '{addi_word(5'd2, 5'd0, 12'hffd), 1'b0};
        stim[2]  = '{addi_word(5'd3, 5'd0, 12'h7ff), 1'b0};
        stim[3]  = '{addi_word(5'd4, 5'd0, 12'd3), 1'b0};
        stim[4]  = '{addi_word(5'd5, 5'd0, 12'h800), 1'b0};
        stim[5]  = '{r_type_word(7'h00, 3'h0, 5'd6, 5'd1, 5'd2), 1'b0};
        stim[6]  = '{r_type_word(7'h20, 3'h0, 5'd7, 5'd1, 5'd3), 1'b0};
        stim[7]  = '{r_type_word(7'h00, 3'h7, 5'd8, 5'd3, 5'd2), 1'b0};
        stim[8]  = '{r_type_word(7'h00, 3'h6, 5'd9, 5'd1, 5'd5), 1'b0};
        stim[9]  = '{r_type_word(7'h00, 3'h4, 5'd10, 5'd2, 5'd3), 1'b0};
        stim[10] = '{r_type_word(7'h00, 3'h2, 5'd11, 5'd2, 5'd1), 1'b0};
        stim[11] = '{r_type_word(7'h00, 3'h2, 5'd12, 5'd2, 5'd5), 1'b0};
        stim[12] = '{addi_word(5'd13, 5'd6, 12'd100), 1'b0};
        // shift by 3, then a consumer of its result.
        stim[13] = '{r_type_word(7'h00, 3'h1, 5'd14, 5'd3, 5'd4), 1'b0};
        stim[14] = '{r_type_word(7'h00, 3'h0, 5'd15, 5'd14, 5'd1), 1'b0};
        stim[15] = '{r_type_word(7'h00, 3'h5, 5'd16, 5'd2, 5'd4), 1'b0};
        // shift by 31 and a zero-length shift of its result.
        stim[16] = '{r_type_word(7'h00, 3'h1, 5'd17, 5'd1, 5'd3), 1'b0};
        stim[17] = '{r_type_word(7'h00, 3'h5, 5'd18, 5'd17, 5'd0), 1'b0};
        stim[18] = '{r_type_word(7'h00, 3'h4, 5'd19, 5'd16, 5'd17), 1'b0};
        stim[19] = '{addi_word(5'd0, 5'd1, 12'd7), 1'b0};
        stim[20] = '{r_type_word(7'h00, 3'h0, 5'd20, 5'd0, 5'd0), 1'b0};
        // undefined opcode, then a load which the core lacks.
        stim[21] = '{32'hffff_ffff, 1'b1};
        stim[22] = '{32'h0000_2083, 1'b1};
        stim[23] = '{r_type_word(7'h00, 3'h0, 5'd21, 5'd1, 5'd20), 1'b0};
        stim[24] = '{r_type_word(7'h20, 3'h0, 5'd22, 5'd0, 5'd1), 1'b0};
    endtask

    // ------------------------------
    // monitor and watchdog
    // ------------------------------

    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (instr_ack_o && !ack_prev && !req_prev) begin
                errors++;
                $display("ERROR at %0t ns: ack rose while req was low", $time);
            end
            if (!instr_ack_o && ack_prev && req_prev) begin
                errors++;
                $display("ERROR at %0t ns: ack fell while req was still high", $time);
            end
            if (illegal_o) begin
                illegal_seen++;
            end
            if (wb_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t ns: writeback to x%0d that no instruction expects",
                             $time, wb_rd_o);
                end else begin
                    head_wb = exp_q.pop_front();
                    check_value("wb_rd_o", wb_rd_o, head_wb.rd);
                    check_value("wb_data_o", wb_data_o, head_wb.data);
                end
            end
        end
        ack_prev = instr_ack_o;
        req_prev = instr_req_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run stopped after %0d cycles, the pipe did not finish", cycles);
            $display("errors: %0d, writebacks still expected: %0d", errors, exp_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        errors           = 0;
        cycles           = 0;
        illegal_seen     = 0;
        illegal_expected = 0;
        ack_prev         = 1'b0;
        req_prev         = 1'b0;
        rstn_i           = 1'b0;
        instr_i          = '0;
        instr_req_i      = 1'b0;
        for (int r = 0; r < `CORE_NREG; r++) begin
            gold_regs[r] = '0;
        end
        fill_table();

        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        check_value("instr_ack_o", instr_ack_o, 32'd0);
        check_value("wb_valid_o", wb_valid_o, 32'd0);
        check_value("illegal_o", illegal_o, 32'd0);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            golden_step(stim[i].instr);
            if (stim[i].illegal) begin
                illegal_expected++;
            end
            apply_instr(stim[i].instr);
        end

        // drain, then idle a little to catch stray writebacks.
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (8) @(posedge clk_i);
        check_value("illegal pulses", illegal_seen, illegal_expected);

        $display("errors: %0d, writebacks still expected: %0d", errors, exp_q.size());
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/core_pkg.sv
hw/stage_reg.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/reg_read_stage.sv
hw/execute_stage.sv
hw/core_pipe_top.sv
sim/tb_core_pipe.sv

//--- Bender.yml
package:
  name: core_pipe

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/stage_reg.sv
      - hw/decode_stage.sv
      - hw/reg_file.sv
      - hw/reg_read_stage.sv
      - hw/execute_stage.sv
      - hw/core_pipe_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_core_pipe.sv
